//--- secv_lsu_pkg.sv
// Sizing constants for the multi-lane load/store subsystem
`default_nettype none

package secv_lsu_pkg;

    // Number of parallel load/store lanes
    localparam int N_LANES = 4;

    // Index into the lane array
    localparam int LANE_WIDTH = $clog2(N_LANES);

    // Operation tag, returned with each result
    localparam int TAG_WIDTH = 4;

    // Byte address into the data RAM, 1 KiB
    localparam int ADR_WIDTH = 10;

    // One byte select per byte of a 64-bit data word
    localparam int SEL_WIDTH = 8;

    // Byte offset inside a data word
    localparam int OFS_WIDTH = $clog2(SEL_WIDTH);

    // Depth of the data RAM in words
    localparam int RAM_WORDS = (2 ** ADR_WIDTH) / SEL_WIDTH;

endpackage

`default_nettype wire

//--- secv_isa_pkg.sv
// RISC-V load/store encodings, operation record and sign-extension helpers
`default_nettype none

package secv_isa_pkg;

    import secv_lsu_pkg::*;

    localparam int XLEN = 64;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    localparam opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam opcode_t OPCODE_STORE = 7'b0100011;

    // Loads, bit 2 selects zero extension
    localparam funct3_t FUNCT3_LOAD_LB  = 3'b000;
    localparam funct3_t FUNCT3_LOAD_LH  = 3'b001;
    localparam funct3_t FUNCT3_LOAD_LW  = 3'b010;
    localparam funct3_t FUNCT3_LOAD_LD  = 3'b011;
    localparam funct3_t FUNCT3_LOAD_LBU = 3'b100;
    localparam funct3_t FUNCT3_LOAD_LHU = 3'b101;
    localparam funct3_t FUNCT3_LOAD_LWU = 3'b110;

    // Stores
    localparam funct3_t FUNCT3_STORE_SB = 3'b000;
    localparam funct3_t FUNCT3_STORE_SH = 3'b001;
    localparam funct3_t FUNCT3_STORE_SW = 3'b010;
    localparam funct3_t FUNCT3_STORE_SD = 3'b011;

    // One memory operation as handed to a lane
    typedef struct packed {
        opcode_t              opcode;
        funct3_t              funct3;
        logic [XLEN-1:0]      rs1_dat;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs2_dat;
        logic [TAG_WIDTH-1:0] tag;
    } lsu_op_t;

    function automatic logic [XLEN-1:0] sext8(input logic [7:0] val);
        return {{(XLEN-8){val[7]}}, val};
    endfunction

    function automatic logic [XLEN-1:0] sext16(input logic [15:0] val);
        return {{(XLEN-16){val[15]}}, val};
    endfunction

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] val);
        return {{(XLEN-32){val[31]}}, val};
    endfunction

endpackage

`default_nettype wire

//--- secv_lsu_if.sv
// Lane issue, lane result and Wishbone classic interfaces of the load/store subsystem
`default_nettype none
`timescale 1ns/1ps

// Dispatcher to lane
interface funit_if import secv_isa_pkg::*; ();
    logic    issue;
    lsu_op_t op;
    logic    busy;

    modport disp (output issue, output op, input busy);
    modport lane (input issue, input op, output busy);
endinterface

// Lane to retire stage
interface lane_res_if import secv_isa_pkg::*, secv_lsu_pkg::*; ();
    logic                 done;
    logic [TAG_WIDTH-1:0] tag;
    logic [XLEN-1:0]      rd_dat;
    logic                 rd_wb;
    logic                 err;
    logic                 retire;

    modport lane (output done, output tag, output rd_dat, output rd_wb, output err,
                  input retire);
    modport ret  (input done, input tag, input rd_dat, input rd_wb, input err,
                  output retire);
endinterface

// Wishbone classic, single beat
interface wb_if import secv_isa_pkg::*, secv_lsu_pkg::*; ();
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [SEL_WIDTH-1:0] sel;
    logic [ADR_WIDTH-1:0] adr;
    logic [XLEN-1:0]      dat_w;
    logic [XLEN-1:0]      dat_r;
    logic                 ack;

    modport master (output cyc, output stb, output we, output sel, output adr,
                    output dat_w, input dat_r, input ack);
    modport slave  (input cyc, input stb, input we, input sel, input adr,
                    input dat_w, output dat_r, output ack);
endinterface

`default_nettype wire

//--- lsu_dispatch.sv
// Operation dispatcher that hands each accepted operation to the lowest free lane
`default_nettype none
`timescale 1ns/1ps

module lsu_dispatch import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 op_valid_i,
    output logic                 op_ready_o,
    input  logic [TAG_WIDTH-1:0] op_tag_i,
    input  opcode_t              op_opcode_i,
    input  funct3_t              op_funct3_i,
    input  logic [XLEN-1:0]      op_rs1_i,
    input  logic [XLEN-1:0]      op_imm_i,
    input  logic [XLEN-1:0]      op_rs2_i,
    funit_if.disp                lanes_o [N_LANES]
);

    logic [N_LANES-1:0] busy;
    logic [N_LANES-1:0] free;
    logic [N_LANES-1:0] pick;
    logic [N_LANES-1:0] issue_q;
    logic               accept;
    lsu_op_t            op_q;

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        assign busy[i]           = lanes_o[i].busy;
        assign lanes_o[i].issue  = issue_q[i];
        assign lanes_o[i].op     = op_q;
    end

    // A lane being issued this cycle is not yet busy but already taken
    assign free       = ~busy & ~issue_q;
    assign pick       = free & (~free + 1'b1);
    assign op_ready_o = |free;
    assign accept     = op_valid_i && op_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_q <= '0;
        end else begin
            issue_q <= accept ? pick : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= '{opcode: op_opcode_i, funct3: op_funct3_i, rs1_dat: op_rs1_i,
                      imm: op_imm_i, rs2_dat: op_rs2_i, tag: op_tag_i};
        end
    end

    a_issue_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_q & busy) == '0)
        else $error("issue to a busy lane");

endmodule

`default_nettype wire

//--- mem_unit.sv
// Load/store lane that checks, aligns and runs one Wishbone access per operation
`default_nettype none
`timescale 1ns/1ps

module mem_unit import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    funit_if.lane    fu,
    lane_res_if.lane res,
    wb_if.master     dmem
);

    typedef enum logic [1:0] {IDLE, BUS, DONE} state_t;

    state_t               state_q;
    logic [ADR_WIDTH-1:0] addr;
    logic [OFS_WIDTH-1:0] ofs;
    logic [1:0]           size;
    logic                 is_store;
    logic                 legal;
    logic                 aligned;
    logic                 bad;
    logic [SEL_WIDTH-1:0] sel;
    logic [XLEN-1:0]      dat_w;
    logic [XLEN-1:0]      rd_raw;
    logic [XLEN-1:0]      load_dat;

    logic [TAG_WIDTH-1:0] tag_q;
    funct3_t              funct3_q;
    logic [OFS_WIDTH-1:0] ofs_q;
    logic [ADR_WIDTH-1:0] adr_q;
    logic                 we_q;
    logic [SEL_WIDTH-1:0] sel_q;
    logic [XLEN-1:0]      dat_w_q;
    logic                 err_q;
    logic                 rd_wb_q;
    logic [XLEN-1:0]      rd_dat_q;

    // Decode and align the operation offered on issue
    always_comb begin
        addr     = ADR_WIDTH'(fu.op.rs1_dat + fu.op.imm);
        ofs      = addr[OFS_WIDTH-1:0];
        size     = fu.op.funct3[1:0];
        is_store = (fu.op.opcode == OPCODE_STORE);
        legal    = 1'b0;
        if (fu.op.opcode == OPCODE_LOAD) begin
            case (fu.op.funct3)
                FUNCT3_LOAD_LB, FUNCT3_LOAD_LH, FUNCT3_LOAD_LW, FUNCT3_LOAD_LD,
                FUNCT3_LOAD_LBU, FUNCT3_LOAD_LHU, FUNCT3_LOAD_LWU: legal = 1'b1;
                default: legal = 1'b0;
            endcase
        end else if (is_store) begin
            case (fu.op.funct3)
                FUNCT3_STORE_SB, FUNCT3_STORE_SH,
                FUNCT3_STORE_SW, FUNCT3_STORE_SD: legal = 1'b1;
                default: legal = 1'b0;
            endcase
        end
        case (size)
            2'd0:    aligned = 1'b1;
            2'd1:    aligned = !ofs[0];
            2'd2:    aligned = !(|ofs[1:0]);
            default: aligned = !(|ofs);
        endcase
        bad   = !legal || !aligned;
        // 1, 2, 4 or 8 byte lanes moved up to the offset
        sel   = SEL_WIDTH'((1 << (1 << size)) - 1) << ofs;
        dat_w = fu.op.rs2_dat << {ofs, 3'b000};
    end

    // Bring the loaded bytes down to bit 0 and extend
    always_comb begin
        rd_raw = dmem.dat_r >> {ofs_q, 3'b000};
        case (funct3_q)
            FUNCT3_LOAD_LB:  load_dat = sext8(rd_raw[7:0]);
            FUNCT3_LOAD_LH:  load_dat = sext16(rd_raw[15:0]);
            FUNCT3_LOAD_LW:  load_dat = sext32(rd_raw[31:0]);
            FUNCT3_LOAD_LBU: load_dat = XLEN'(rd_raw[7:0]);
            FUNCT3_LOAD_LHU: load_dat = XLEN'(rd_raw[15:0]);
            FUNCT3_LOAD_LWU: load_dat = XLEN'(rd_raw[31:0]);
            default:         load_dat = rd_raw;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (fu.issue) state_q <= bad ? DONE : BUS;
                BUS:  if (dmem.ack) state_q <= DONE;
                DONE: if (res.retire) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && fu.issue) begin
            tag_q    <= fu.op.tag;
            funct3_q <= fu.op.funct3;
            ofs_q    <= ofs;
            adr_q    <= addr;
            we_q     <= is_store;
            sel_q    <= sel;
            dat_w_q  <= dat_w;
            err_q    <= bad;
            rd_wb_q  <= 1'b0;
            rd_dat_q <= '0;
        end else if (state_q == BUS && dmem.ack) begin
            rd_dat_q <= we_q ? '0 : load_dat;
            rd_wb_q  <= !we_q;
        end
    end

    assign fu.busy    = (state_q != IDLE);
    assign dmem.cyc   = (state_q == BUS);
    assign dmem.stb   = (state_q == BUS);
    assign dmem.we    = we_q;
    assign dmem.sel   = sel_q;
    assign dmem.adr   = adr_q;
    assign dmem.dat_w = dat_w_q;

    assign res.done   = (state_q == DONE);
    assign res.tag    = tag_q;
    assign res.rd_dat = rd_dat_q;
    assign res.rd_wb  = rd_wb_q;
    assign res.err    = err_q;

    // Strobe held together with cyc until the slave answers
    a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem.stb && !dmem.ack |=> dmem.stb && dmem.cyc)
        else $error("stb dropped before ack or raised without cyc");

endmodule

`default_nettype wire

//--- wb_arbiter.sv
// Round-robin arbiter that puts one lane at a time onto the data memory bus
`default_nettype none
`timescale 1ns/1ps

module wb_arbiter import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    wb_if.slave  lanes [N_LANES],
    wb_if.master mem
);

    logic [N_LANES-1:0]    cyc;
    logic [N_LANES-1:0]    stb;
    logic [N_LANES-1:0]    we;
    logic [SEL_WIDTH-1:0]  sel   [N_LANES];
    logic [ADR_WIDTH-1:0]  adr   [N_LANES];
    logic [XLEN-1:0]       dat_w [N_LANES];
    logic [LANE_WIDTH-1:0] ptr_q;
    logic [LANE_WIDTH-1:0] nxt;
    logic [LANE_WIDTH-1:0] gnt;

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        assign cyc[i]         = lanes[i].cyc;
        assign stb[i]         = lanes[i].stb;
        assign we[i]          = lanes[i].we;
        assign sel[i]         = lanes[i].sel;
        assign adr[i]         = lanes[i].adr;
        assign dat_w[i]       = lanes[i].dat_w;
        assign lanes[i].ack   = mem.ack && (gnt == LANE_WIDTH'(i));
        assign lanes[i].dat_r = (gnt == LANE_WIDTH'(i)) ? mem.dat_r : '0;

        a_ack_to_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            lanes[i].ack |-> lanes[i].cyc)
            else $error("ack to lane %0d without cyc", i);
    end

    // Nearest requester after the last served lane wins
    always_comb begin
        logic [LANE_WIDTH-1:0] idx;
        nxt = ptr_q;
        for (int k = N_LANES; k >= 1; k--) begin
            idx = LANE_WIDTH'((int'(ptr_q) + k) % N_LANES);
            if (cyc[idx]) begin
                nxt = idx;
            end
        end
    end

    // Hold the grant while its cycle is open
    assign gnt = cyc[ptr_q] ? ptr_q : nxt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= gnt;
        end
    end

    assign mem.cyc   = cyc[gnt];
    assign mem.stb   = stb[gnt];
    assign mem.we    = we[gnt];
    assign mem.sel   = sel[gnt];
    assign mem.adr   = adr[gnt];
    assign mem.dat_w = dat_w[gnt];

endmodule

`default_nettype wire

//--- lsu_retire.sv
// Retire stage that presents the lowest finished lane's result to the core
`default_nettype none
`timescale 1ns/1ps

module lsu_retire import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    lane_res_if.ret              lanes_i [N_LANES],
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output logic [TAG_WIDTH-1:0] res_tag_o,
    output logic [XLEN-1:0]      res_dat_o,
    output logic                 res_wb_o,
    output logic                 res_err_o
);

    logic [N_LANES-1:0]    done;
    logic [N_LANES-1:0]    wb;
    logic [N_LANES-1:0]    err;
    logic [TAG_WIDTH-1:0]  tag [N_LANES];
    logic [XLEN-1:0]       dat [N_LANES];
    logic [LANE_WIDTH-1:0] sel;
    logic                  take;

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        assign done[i]           = lanes_i[i].done;
        assign wb[i]             = lanes_i[i].rd_wb;
        assign err[i]            = lanes_i[i].err;
        assign tag[i]            = lanes_i[i].tag;
        assign dat[i]            = lanes_i[i].rd_dat;
        assign lanes_i[i].retire = take && (sel == LANE_WIDTH'(i));
    end

    // Lowest index with a result
    always_comb begin
        sel = '0;
        for (int i = N_LANES - 1; i >= 0; i--) begin
            if (done[i]) begin
                sel = LANE_WIDTH'(i);
            end
        end
    end

    assign res_valid_o = |done;
    assign take        = res_valid_o && res_ready_i;
    assign res_tag_o   = tag[sel];
    assign res_dat_o   = dat[sel];
    assign res_wb_o    = wb[sel];
    assign res_err_o   = err[sel];

    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o)
        else $error("result dropped before it was consumed");

endmodule

`default_nettype wire

//--- data_ram.sv
// Wishbone classic data RAM with byte-select writes and a registered ack
`default_nettype none
`timescale 1ns/1ps

module data_ram import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    wb_if.slave  bus
);

    logic [XLEN-1:0]                mem [RAM_WORDS];
    logic [ADR_WIDTH-OFS_WIDTH-1:0] word;
    logic [XLEN-1:0]                dat_r_q;
    logic                           ack_q;
    logic                           req;

    assign word = bus.adr[ADR_WIDTH-1:OFS_WIDTH];
    // New request, not the tail of the one being acked
    assign req  = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            dat_r_q <= mem[word];
            for (int b = 0; b < SEL_WIDTH; b++) begin
                if (bus.we && bus.sel[b]) begin
                    mem[word][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_r_q;

endmodule

`default_nettype wire

//--- lsu_top.sv
// Load/store subsystem with parallel lanes sharing one data RAM
`default_nettype none
`timescale 1ns/1ps

module lsu_top import secv_isa_pkg::*, secv_lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 op_valid_i,
    output logic                 op_ready_o,
    input  logic [TAG_WIDTH-1:0] op_tag_i,
    input  opcode_t              op_opcode_i,
    input  funct3_t              op_funct3_i,
    input  logic [XLEN-1:0]      op_rs1_i,
    input  logic [XLEN-1:0]      op_imm_i,
    input  logic [XLEN-1:0]      op_rs2_i,
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output logic [TAG_WIDTH-1:0] res_tag_o,
    output logic [XLEN-1:0]      res_dat_o,
    output logic                 res_wb_o,
    output logic                 res_err_o
);

    funit_if    fu       [N_LANES] ();
    lane_res_if res      [N_LANES] ();
    wb_if       lane_bus [N_LANES] ();
    wb_if       mem_bus ();

    lsu_dispatch u_dispatch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .op_tag_i    (op_tag_i),
        .op_opcode_i (op_opcode_i),
        .op_funct3_i (op_funct3_i),
        .op_rs1_i    (op_rs1_i),
        .op_imm_i    (op_imm_i),
        .op_rs2_i    (op_rs2_i),
        .lanes_o     (fu)
    );

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        mem_unit u_lane (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .fu      (fu[i]),
            .res     (res[i]),
            .dmem    (lane_bus[i])
        );
    end

    wb_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .lanes   (lane_bus),
        .mem     (mem_bus)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (mem_bus)
    );

    lsu_retire u_retire (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lanes_i     (res),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_tag_o   (res_tag_o),
        .res_dat_o   (res_dat_o),
        .res_wb_o    (res_wb_o),
        .res_err_o   (res_err_o)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Testbench clock source with a 10 ns period
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb_lsu_top.sv
// Directed and random testbench for the load/store subsystem with a byte-level memory model
`default_nettype none
`timescale 1ns/1ps

module tb_lsu_top import secv_isa_pkg::*, secv_lsu_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int MAX_OPS        = 300;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * MAX_OPS;
    localparam int RAND_OPS       = 200;

    logic                 clk;
    logic                 rst_n_i;
    logic                 op_valid_i;
    logic                 op_ready_o;
    logic [TAG_WIDTH-1:0] op_tag_i;
    opcode_t              op_opcode_i;
    funct3_t              op_funct3_i;
    logic [XLEN-1:0]      op_rs1_i;
    logic [XLEN-1:0]      op_imm_i;
    logic [XLEN-1:0]      op_rs2_i;
    logic                 res_valid_o;
    logic                 res_ready_i;
    logic [TAG_WIDTH-1:0] res_tag_o;
    logic [XLEN-1:0]      res_dat_o;
    logic                 res_wb_o;
    logic                 res_err_o;

    // Reference memory and per-tag expectations
    logic [7:0]           ref_mem  [2 ** ADR_WIDTH];
    logic                 pend     [2 ** TAG_WIDTH];
    logic                 pend_st  [2 ** TAG_WIDTH];
    logic                 exp_err  [2 ** TAG_WIDTH];
    logic                 exp_wb   [2 ** TAG_WIDTH];
    logic [XLEN-1:0]      exp_dat  [2 ** TAG_WIDTH];
    logic [ADR_WIDTH-4:0] pend_wrd [2 ** TAG_WIDTH];

    // Operation waiting to be accepted
    logic                 offer;
    logic [TAG_WIDTH-1:0] nxt_tag;
    opcode_t              nxt_opcode;
    funct3_t              nxt_funct3;
    logic [XLEN-1:0]      nxt_rs1;
    logic [XLEN-1:0]      nxt_imm;
    logic [XLEN-1:0]      nxt_rs2;

    integer seed;
    int     ready_mode;
    int     errors;
    int     checks;
    int     issued;
    int     returned;
    int     cycle_cnt;
    string  cur_test;

    tb_clkgen u_clkgen (
        .clk_o (clk)
    );

    lsu_top u_lsu_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n_i),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .op_tag_i    (op_tag_i),
        .op_opcode_i (op_opcode_i),
        .op_funct3_i (op_funct3_i),
        .op_rs1_i    (op_rs1_i),
        .op_imm_i    (op_imm_i),
        .op_rs2_i    (op_rs2_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_tag_o   (res_tag_o),
        .res_dat_o   (res_dat_o),
        .res_wb_o    (res_wb_o),
        .res_err_o   (res_err_o)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing, %0d errors so far",
                     cycle_cnt, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [7:0] fill_byte(input logic [ADR_WIDTH-1:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h3c;
    endfunction

    function automatic logic word_in_use(input logic [ADR_WIDTH-4:0] wrd, input logic st);
        logic hit;
        hit = 1'b0;
        for (int t = 0; t < 2 ** TAG_WIDTH; t++) begin
            if (pend[t] && !exp_err[t] && pend_wrd[t] == wrd && (st || pend_st[t])) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int t = 0; t < 2 ** TAG_WIDTH; t++) begin
            n += pend[t];
        end
        return n;
    endfunction

    task automatic check_result();
        logic [TAG_WIDTH-1:0] t;
        t = res_tag_o;
        checks++;
        assert (pend[t]) else begin
            errors++;
            $display("%s: result came back with tag %0d, which is not outstanding", cur_test, t);
        end
        if (pend[t]) begin
            assert (res_err_o == exp_err[t]) else begin
                errors++;
                $display("FAILED %s tag %0d err: expected %0b, actual %0b",
                         cur_test, t, exp_err[t], res_err_o);
            end
            assert (res_wb_o == exp_wb[t]) else begin
                errors++;
                $display("FAILED %s tag %0d wb: expected %0b, actual %0b",
                         cur_test, t, exp_wb[t], res_wb_o);
            end
            if (exp_wb[t]) begin
                assert (res_dat_o === exp_dat[t]) else begin
                    errors++;
                    $display("FAILED %s tag %0d data: expected %h, actual %h",
                             cur_test, t, exp_dat[t], res_dat_o);
                end
            end
            pend[t] = 1'b0;
            returned++;
        end
    endtask

    // One clock: drive on the falling edge, then see what the next rising edge will take
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        case (ready_mode)
            0:       res_ready_i = 1'b0;
            1:       res_ready_i = 1'b1;
            default: begin
                rnd = $random(seed);
                res_ready_i = rnd[0];
            end
        endcase
        op_valid_i  = offer;
        op_tag_i    = nxt_tag;
        op_opcode_i = nxt_opcode;
        op_funct3_i = nxt_funct3;
        op_rs1_i    = nxt_rs1;
        op_imm_i    = nxt_imm;
        op_rs2_i    = nxt_rs2;
        if (res_valid_o && res_ready_i) begin
            check_result();
        end
        if (offer && op_ready_o) begin
            offer = 1'b0;
        end
    endtask

    // Predict the result, update the model for a store and present the operation
    task automatic offer_op(input logic [TAG_WIDTH-1:0] tag, input opcode_t opc,
                            input funct3_t f3, input logic [XLEN-1:0] rs1,
                            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] rs2);
        logic [ADR_WIDTH-1:0] addr;
        logic [XLEN-1:0]      val;
        logic                 legal;
        logic                 bad;
        logic                 st;
        int                   size;
        addr = ADR_WIDTH'(rs1 + imm);
        size = 1 << f3[1:0];
        st   = (opc == OPCODE_STORE);
        if (opc == OPCODE_LOAD) begin
            legal = (f3 != 3'b111);
        end else begin
            legal = st && !f3[2];
        end
        bad = !legal || (addr % size != 0);
        // Keep memory order by waiting out any in-flight access to the same word
        while (pend[tag] || (!bad && word_in_use(addr[ADR_WIDTH-1:3], st))) begin
            next_cycle();
        end
        val = '0;
        if (!bad && !st) begin
            for (int i = size - 1; i >= 0; i--) begin
                val = (val << 8) | XLEN'(ref_mem[addr + i]);
            end
            if (!f3[2] && size < 8 && val[8*size-1]) begin
                val = val | ~((64'd1 << (8 * size)) - 1);
            end
        end
        if (!bad && st) begin
            for (int i = 0; i < size; i++) begin
                ref_mem[addr + i] = rs2[8*i +: 8];
            end
        end
        pend[tag]     = 1'b1;
        pend_st[tag]  = st;
        pend_wrd[tag] = addr[ADR_WIDTH-1:3];
        exp_err[tag]  = bad;
        exp_wb[tag]   = !bad && !st;
        exp_dat[tag]  = val;
        issued++;
        nxt_tag    = tag;
        nxt_opcode = opc;
        nxt_funct3 = f3;
        nxt_rs1    = rs1;
        nxt_imm    = imm;
        nxt_rs2    = rs2;
        offer      = 1'b1;
    endtask

    task automatic send_op(input logic [TAG_WIDTH-1:0] tag, input opcode_t opc,
                           input funct3_t f3, input logic [XLEN-1:0] rs1,
                           input logic [XLEN-1:0] imm, input logic [XLEN-1:0] rs2);
        offer_op(tag, opc, f3, rs1, imm, rs2);
        while (offer) begin
            next_cycle();
        end
    endtask

    task automatic drain_results();
        while (outstanding() != 0) begin
            next_cycle();
        end
    endtask

    // Known contents for the low 256 bytes
    task automatic fill_ram();
        logic [XLEN-1:0] dat;
        cur_test   = "fill";
        ready_mode = 1;
        for (int w = 0; w < 32; w++) begin
            for (int b = 0; b < 8; b++) begin
                dat[8*b +: 8] = fill_byte(ADR_WIDTH'(w * 8 + b));
            end
            send_op(TAG_WIDTH'(w), OPCODE_STORE, FUNCT3_STORE_SD, XLEN'(w * 8), '0, dat);
        end
        drain_results();
    endtask

    task automatic test_reset();
        cur_test = "reset";
        @(negedge clk);
        assert (res_valid_o === 1'b0) else begin
            errors++;
            $display("FAILED %s res_valid_o: expected 0, actual %b", cur_test, res_valid_o);
        end
        assert (op_ready_o === 1'b1) else begin
            errors++;
            $display("FAILED %s op_ready_o: expected 1, actual %b", cur_test, op_ready_o);
        end
    endtask

    task automatic test_loads();
        cur_test = "loads";
        send_op(4'd1, OPCODE_STORE, FUNCT3_STORE_SD, 64'h40, '0, 64'h89ab_cdef_8123_f567);
        send_op(4'd2, OPCODE_LOAD, FUNCT3_LOAD_LD,  64'h40, 64'h0, '0);
        send_op(4'd3, OPCODE_LOAD, FUNCT3_LOAD_LD,  64'h50, -64'sd16, '0);
        send_op(4'd4, OPCODE_LOAD, FUNCT3_LOAD_LW,  64'h40, 64'h0, '0);
        send_op(4'd5, OPCODE_LOAD, FUNCT3_LOAD_LW,  64'h40, 64'h4, '0);
        send_op(4'd6, OPCODE_LOAD, FUNCT3_LOAD_LWU, 64'h40, 64'h4, '0);
        send_op(4'd7, OPCODE_LOAD, FUNCT3_LOAD_LH,  64'h40, 64'h2, '0);
        send_op(4'd8, OPCODE_LOAD, FUNCT3_LOAD_LH,  64'h40, 64'h6, '0);
        send_op(4'd9, OPCODE_LOAD, FUNCT3_LOAD_LHU, 64'h40, 64'h6, '0);
        send_op(4'd10, OPCODE_LOAD, FUNCT3_LOAD_LB,  64'h40, 64'h7, '0);
        send_op(4'd11, OPCODE_LOAD, FUNCT3_LOAD_LBU, 64'h40, 64'h7, '0);
        send_op(4'd12, OPCODE_LOAD, FUNCT3_LOAD_LB,  64'h40, 64'h3, '0);
        drain_results();
    endtask

    task automatic test_narrow_stores();
        logic [31:0] rnd;
        int          size;
        int          t;
        cur_test = "narrow_stores";
        t = 0;
        for (int f = 0; f < 3; f++) begin
            size = 1 << f;
            for (int ofs = 0; ofs < 8; ofs += size) begin
                rnd = $random(seed);
                send_op(TAG_WIDTH'(t), OPCODE_STORE, funct3_t'(f), 64'h80, XLEN'(ofs),
                        {rnd, ~rnd});
                send_op(TAG_WIDTH'(t + 1), OPCODE_LOAD, FUNCT3_LOAD_LD, 64'h80, '0, '0);
                t = (t + 2) % 16;
            end
        end
        drain_results();
    endtask

    task automatic test_errors();
        cur_test = "errors";
        send_op(4'd1, OPCODE_LOAD, FUNCT3_LOAD_LH, 64'h40, 64'h1, '0);
        send_op(4'd2, OPCODE_LOAD, FUNCT3_LOAD_LW, 64'h40, 64'h2, '0);
        send_op(4'd3, OPCODE_STORE, FUNCT3_STORE_SD, 64'h40, 64'h4, '1);
        send_op(4'd4, OPCODE_LOAD, 3'b111, 64'h40, '0, '0);
        send_op(4'd5, OPCODE_STORE, 3'b100, 64'h40, '0, '1);
        send_op(4'd6, 7'b0110011, FUNCT3_LOAD_LD, 64'h40, '0, '1);
        drain_results();
        send_op(4'd7, OPCODE_LOAD, FUNCT3_LOAD_LD, 64'h40, '0, '0);
        send_op(4'd8, OPCODE_LOAD, FUNCT3_LOAD_LD, 64'h48, '0, '0);
        drain_results();
    endtask

    task automatic test_backpressure();
        cur_test   = "backpressure";
        ready_mode = 0;
        for (int i = 0; i < 4; i++) begin
            send_op(TAG_WIDTH'(i + 3), OPCODE_LOAD, FUNCT3_LOAD_LD, XLEN'(i * 8), '0, '0);
        end
        offer_op(4'd9, OPCODE_LOAD, FUNCT3_LOAD_LW, 64'h20, 64'h4, '0);
        repeat (8) begin
            next_cycle();
            assert (op_ready_o === 1'b0) else begin
                errors++;
                $display("FAILED %s op_ready_o: expected 0, actual %b", cur_test, op_ready_o);
            end
        end
        assert (offer) else begin
            errors++;
            $display("%s: fifth operation was taken while all lanes were full", cur_test);
        end
        ready_mode = 1;
        while (offer) begin
            next_cycle();
        end
        drain_results();
    endtask

    task automatic test_random();
        logic [31:0]          rnd;
        logic [ADR_WIDTH-1:0] addr;
        logic [XLEN-1:0]      imm;
        logic [TAG_WIDTH-1:0] tag;
        funct3_t              f3;
        logic                 st;
        int                   start;
        cur_test   = "random";
        ready_mode = 2;
        start      = checks;
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd = $random(seed);
            st  = rnd[0];
            f3  = st ? {1'b0, rnd[2:1]} : ((rnd[3:1] == 3'b111) ? 3'b011 : rnd[3:1]);
            // Aligned offset inside one of the 32 filled words
            addr = {rnd[8:4], rnd[11:9] & ~3'((1 << f3[1:0]) - 1)};
            imm  = {{52{rnd[23]}}, rnd[23:12]};
            do begin
                rnd = $random(seed);
                tag = rnd[3:0];
            end while (pend[tag]);
            rnd = $random(seed);
            send_op(tag, st ? OPCODE_STORE : OPCODE_LOAD, f3, XLEN'(addr) - imm, imm,
                    {rnd, $random(seed)});
        end
        drain_results();
        // Every result seen on the port counts, stray or duplicate tags included
        assert (checks - start == RAND_OPS) else begin
            errors++;
            $display("FAILED %s result count: expected %0d, actual %0d",
                     cur_test, RAND_OPS, checks - start);
        end
    endtask

    initial begin
        seed        = 47820;
        errors      = 0;
        checks      = 0;
        issued      = 0;
        returned    = 0;
        cycle_cnt   = 0;
        ready_mode  = 1;
        offer       = 1'b0;
        rst_n_i     = 1'b0;
        op_valid_i  = 1'b0;
        op_tag_i    = '0;
        op_opcode_i = '0;
        op_funct3_i = '0;
        op_rs1_i    = '0;
        op_imm_i    = '0;
        op_rs2_i    = '0;
        res_ready_i = 1'b0;
        nxt_tag     = '0;
        nxt_opcode  = '0;
        nxt_funct3  = '0;
        nxt_rs1     = '0;
        nxt_imm     = '0;
        nxt_rs2     = '0;
        for (int i = 0; i < 2 ** ADR_WIDTH; i++) begin
            ref_mem[i] = 8'h00;
        end
        for (int t = 0; t < 2 ** TAG_WIDTH; t++) begin
            pend[t] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        test_reset();
        fill_ram();
        test_loads();
        test_narrow_stores();
        test_errors();
        test_backpressure();
        test_random();

        $display("Issued %0d, returned %0d, checks %0d, errors %0d",
                 issued, returned, checks, errors);
        if (errors == 0 && issued == returned) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
secv_lsu_pkg.sv
secv_isa_pkg.sv
secv_lsu_if.sv
lsu_dispatch.sv
mem_unit.sv
wb_arbiter.sv
lsu_retire.sv
data_ram.sv
lsu_top.sv
tb_clkgen.sv
tb_lsu_top.sv
